// File: src.f
source/thr_pkg.sv
source/wb_pkg.sv
source/thread_fsm.sv
source/thread_picker.sv
source/thread_dbg_wb.sv
source/thread_switch_top.sv
tb/thread_switch_tb.sv

// File: tb/thread_switch_vectors.txt
# C reps start thaw rst nuke halt int stall compl spec ldhit swc  s0 s1 s2 s3 run_valid run_id
# states and run status are those seen during the cycle, before its events act; all hex
# W adr data = wishbone write, R adr data = wishbone read with expected data
C 1 5 0 0 0 0 0 0 0 0 0 0 00 00 00 00 0 0
C 1 0 0 0 0 0 0 0 0 0 0 0 19 00 19 00 0 0
C 1 0 0 0 0 0 0 1 0 0 0 0 05 00 19 00 0 0
C 1 0 0 0 0 0 0 0 0 0 0 0 01 00 19 00 1 0
C 1 0 0 0 0 0 0 0 0 0 0 0 01 00 05 00 0 0
C 1 0 0 0 0 0 0 4 0 0 0 0 01 00 05 00 1 2
C 1 2 0 0 0 0 0 0 5 0 0 0 01 00 01 00 1 2
C 1 0 0 0 0 0 0 0 0 0 0 0 19 19 19 00 0 0
C 1 0 0 0 0 0 0 0 0 0 0 0 05 19 19 00 0 0
C 7 0 0 0 0 0 0 0 0 0 0 0 05 19 19 00 1 0
C 1 0 0 0 0 0 0 0 0 0 0 0 19 19 19 00 1 0
C 1 0 0 0 0 0 0 0 0 0 0 0 19 05 19 00 0 0
C 7 0 0 0 0 0 0 0 0 0 0 0 19 05 19 00 1 1
C 1 0 0 0 0 0 0 0 0 0 0 0 19 19 19 00 1 1
C 1 0 0 0 0 0 0 0 0 0 0 0 19 19 05 00 0 0
C 7 0 0 0 0 0 0 0 0 0 0 0 19 19 05 00 1 2
C 1 0 0 0 0 0 0 0 0 0 0 0 19 19 19 00 1 2
C 1 0 0 0 0 0 0 0 0 0 0 0 05 19 19 00 0 0
C 1 0 0 0 0 0 0 6 0 0 0 0 05 19 19 00 1 0
C c 0 0 0 0 0 0 0 0 0 0 0 05 01 01 00 1 0
C 1 0 0 0 0 0 0 0 0 0 0 1 05 01 01 00 1 0
C 1 0 0 0 0 4 0 0 2 0 0 0 01 01 01 00 1 0
C 1 0 0 0 1 0 4 0 0 0 0 0 01 19 02 00 0 0
C 1 0 0 0 0 0 0 2 0 0 0 0 00 05 19 00 0 0
C 1 0 0 0 0 0 0 0 0 2 0 0 00 01 19 00 1 1
C 1 0 0 0 0 0 0 4 0 0 0 0 00 13 05 00 0 0
C 1 0 0 0 0 0 0 0 0 0 0 0 00 13 01 00 1 2
C 1 0 0 0 0 0 0 0 0 0 2 0 00 07 01 00 0 0
C 1 0 0 0 0 0 0 0 4 0 0 1 00 05 01 00 1 1
C 1 0 0 0 0 0 0 0 0 2 0 0 00 01 19 00 1 1
C 1 0 0 0 0 0 0 0 0 0 0 0 00 13 05 00 0 0
C 7 0 0 0 0 0 0 0 0 0 0 0 00 13 05 00 1 2
C 1 0 0 0 0 0 0 0 0 0 0 0 00 13 19 00 1 2
C 1 0 0 0 0 0 0 0 0 0 0 0 00 07 19 00 0 0
C 7 0 0 0 0 0 0 0 0 0 0 0 00 07 19 00 1 1
C 1 0 0 0 0 0 0 0 0 0 0 0 00 13 19 00 1 1
C 1 0 0 0 0 0 0 0 0 0 0 0 00 13 05 00 0 0
C 1 0 0 0 0 0 0 2 0 0 0 0 00 13 05 00 1 2
R 0 00
R 1 01
R 2 05
R 3 00
R 5 00
R f 82
W 3 02
R 3 02
W 0 01
R 0 01
W 1 05
W 1 0a
R 1 01
W 2 01
R 2 05
W 6 19
R f 82
W 1 19
C 1 0 0 0 0 0 0 0 0 0 0 0 01 19 19 02 1 2
C 1 0 0 0 0 0 0 0 0 0 0 0 01 05 19 02 0 0
C 1 0 0 0 0 0 0 0 0 0 0 0 01 05 19 02 1 1
W 1 01
R 1 05
R f 81

// File: tb/thread_switch_tb.sv
/* thread switch testbench
   replays cycle vectors and wishbone accesses against the thread switch top */
`timescale 1ns/1ns

module thread_switch_tb
   import thr_pkg::*;
   import wb_pkg::*;
();

   localparam int NUM_THREADS = 4;
   localparam int QUANTUM     = 8;
   localparam int IDX_W       = $clog2(NUM_THREADS);
   localparam int ACK_TIMEOUT = 20;   // cycles

   logic                                    clk;
   logic                                    reset;
   logic [NUM_THREADS-1:0]                  start_thread;
   logic [NUM_THREADS-1:0]                  thaw_thread;
   logic [NUM_THREADS-1:0]                  rst_thread;
   logic [NUM_THREADS-1:0]                  nuke_thread;
   logic [NUM_THREADS-1:0]                  halt_thread;
   logic [NUM_THREADS-1:0]                  int_activate;
   logic [NUM_THREADS-1:0]                  stall;
   logic [NUM_THREADS-1:0]                  completion;
   logic [NUM_THREADS-1:0]                  spec_ld;
   logic [NUM_THREADS-1:0]                  ldhit;
   logic                                    sw_cond;
   logic                                    wb_cyc;
   logic                                    wb_stb;
   logic                                    wb_we;
   logic [WB_ADDR_W-1:0]                    wb_adr;
   logic [WB_DATA_W-1:0]                    wb_dat_w;
   logic [WB_DATA_W-1:0]                    wb_dat_r;
   logic                                    wb_ack;
   logic [NUM_THREADS-1:0][THR_STATE_W-1:0] thread_states;
   logic                                    run_valid;
   logic [IDX_W-1:0]                        run_id;

   int                     fd;                           // vector file handle
   int                     entry;                        // vector number in error lines
   int                     reps;
   logic [NUM_THREADS-1:0] ev_next [0:9];                // event buses, file column order
   logic                   sw_next;
   logic [THR_STATE_W-1:0] exp_state [0:NUM_THREADS-1];
   logic                   exp_rv;
   logic [IDX_W-1:0]       exp_rid;

   thread_switch_top #(
      .NUM_THREADS (NUM_THREADS),
      .QUANTUM     (QUANTUM)
   ) dut0 (
      .clk           (clk),
      .reset         (reset),
      .start_thread  (start_thread),
      .thaw_thread   (thaw_thread),
      .rst_thread    (rst_thread),
      .nuke_thread   (nuke_thread),
      .halt_thread   (halt_thread),
      .int_activate  (int_activate),
      .stall         (stall),
      .completion    (completion),
      .spec_ld       (spec_ld),
      .ldhit         (ldhit),
      .sw_cond       (sw_cond),
      .wb_cyc        (wb_cyc),
      .wb_stb        (wb_stb),
      .wb_we         (wb_we),
      .wb_adr        (wb_adr),
      .wb_dat_w      (wb_dat_w),
      .wb_dat_r      (wb_dat_r),
      .wb_ack        (wb_ack),
      .thread_states (thread_states),
      .run_valid     (run_valid),
      .run_id        (run_id)
   );

   always #2 clk = ~clk;   // 4 ns period

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
         fail_run($sformatf("** Error %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
   endtask

   // copy the staged events onto the DUT pins
   task automatic drive_events();
      start_thread = ev_next[0];
      thaw_thread  = ev_next[1];
      rst_thread   = ev_next[2];
      nuke_thread  = ev_next[3];
      halt_thread  = ev_next[4];
      int_activate = ev_next[5];
      stall        = ev_next[6];
      completion   = ev_next[7];
      spec_ld      = ev_next[8];
      ldhit        = ev_next[9];
      sw_cond      = sw_next;
   endtask

   task automatic clear_events();
      for (int k = 0; k < 10; k++)
         ev_next[k] = '0;
      sw_next = 1'b0;
      drive_events();   // bus accesses run with all events quiet
   endtask

   task automatic run_cycles();
      string tag;
      for (int r = 0; r < reps; r++)
      begin
         @(posedge clk);
         #1;
         drive_events();
         #2;               // just before the next edge
         tag = $sformatf("vector %0d cycle %0d", entry, r);
         for (int i = 0; i < NUM_THREADS; i++)
            check_value($sformatf("%s thread %0d state", tag, i), exp_state[i], thread_states[i]);
         check_value({tag, " run_valid"}, exp_rv, run_valid);
         check_value({tag, " run_id"}, exp_rid, run_id);
      end
   endtask

   // one request, held until the ack shows up
   task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                            input logic [WB_DATA_W-1:0] data);
      int   waited;
      logic ack_seen;
      @(posedge clk);
      #1;
      clear_events();
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = data;
      waited   = 0;
      ack_seen = 1'b0;
      while (!ack_seen && waited < ACK_TIMEOUT)
      begin
         @(posedge clk);
         #1;
         ack_seen = wb_ack;
         waited++;
      end
      if (!ack_seen)
         fail_run($sformatf("no wb_ack within %0d cycles at vector %0d", ACK_TIMEOUT, entry));
      wb_cyc = 1'b0;   // drop the request in the ack cycle
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic read_cycle_line();
      int n;
      n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", reps,
                  ev_next[0], ev_next[1], ev_next[2], ev_next[3], ev_next[4],
                  ev_next[5], ev_next[6], ev_next[7], ev_next[8], ev_next[9], sw_next);
      n += $fscanf(fd, "%h %h %h %h %h %h", exp_state[0], exp_state[1],
                   exp_state[2], exp_state[3], exp_rv, exp_rid);
      if (n != 18)
         fail_run($sformatf("vector %0d is a cycle line with missing fields", entry));
   endtask

   initial
   begin
      byte                  kind;
      int                   n;
      string                line_buf;
      logic [WB_ADDR_W-1:0] adr;
      logic [WB_DATA_W-1:0] data;
      clk      = 1'b0;
      reset    = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      entry    = 0;
      clear_events();
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      fd = $fopen("tb/thread_switch_vectors.txt", "r");
      if (fd == 0)
         fail_run("cannot open the vector file tb/thread_switch_vectors.txt");
      while (!$feof(fd))
      begin
         n = $fscanf(fd, " %c", kind);
         if (n == 1)
         begin
            entry++;
            case (kind)
               "#": n = $fgets(line_buf, fd);   // comment line
               "C":
               begin
                  read_cycle_line();
                  run_cycles();
               end
               "W":
               begin
                  if ($fscanf(fd, "%h %h", adr, data) != 2)
                     fail_run($sformatf("vector %0d is a write line with missing fields", entry));
                  wb_access(1'b1, adr, data);
               end
               "R":
               begin
                  if ($fscanf(fd, "%h %h", adr, data) != 2)
                     fail_run($sformatf("vector %0d is a read line with missing fields", entry));
                  wb_access(1'b0, adr, '0);
                  check_value($sformatf("vector %0d read 0x%0h", entry, adr), data, wb_dat_r);
               end
               default:
                  fail_run($sformatf("vector %0d has unknown line type %c", entry, kind));
            endcase
         end
      end
      $fclose(fd);
      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: source/thread_switch_top.sv
/* thread switch control top
   per-thread FSMs, round-robin picker and wishbone debug port */
`timescale 1ns/1ns

module thread_switch_top
   import thr_pkg::*;
   import wb_pkg::*;
#(
   parameter  int NUM_THREADS = 4,
   parameter  int QUANTUM     = 8,
   localparam int IDX_W       = $clog2(NUM_THREADS)
)
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic [NUM_THREADS-1:0]                  start_thread,
   input  logic [NUM_THREADS-1:0]                  thaw_thread,
   input  logic [NUM_THREADS-1:0]                  rst_thread,
   input  logic [NUM_THREADS-1:0]                  nuke_thread,
   input  logic [NUM_THREADS-1:0]                  halt_thread,
   input  logic [NUM_THREADS-1:0]                  int_activate,
   input  logic [NUM_THREADS-1:0]                  stall,
   input  logic [NUM_THREADS-1:0]                  completion,
   input  logic [NUM_THREADS-1:0]                  spec_ld,
   input  logic [NUM_THREADS-1:0]                  ldhit,
   input  logic                                    sw_cond,    // shared, running thread only
   input  logic                                    wb_cyc,
   input  logic                                    wb_stb,
   input  logic                                    wb_we,
   input  logic [WB_ADDR_W-1:0]                    wb_adr,
   input  logic [WB_DATA_W-1:0]                    wb_dat_w,
   output logic [WB_DATA_W-1:0]                    wb_dat_r,
   output logic                                    wb_ack,
   output logic [NUM_THREADS-1:0][THR_STATE_W-1:0] thread_states,
   output logic                                    run_valid,
   output logic [IDX_W-1:0]                        run_id
);

   logic [NUM_THREADS-1:0] schedule;
   logic [NUM_THREADS-1:0] switch_out;
   logic [NUM_THREADS-1:0] dbg_wr_en;
   thr_state_e             dbg_wr_data;   // same code offered to every thread

   for (genvar i = 0; i < NUM_THREADS; i++)
   begin : fsm_g
      thread_fsm fsm (
         .clk          (clk),
         .reset        (reset),
         .completion   (completion[i]),
         .schedule     (schedule[i]),
         .spec_ld      (spec_ld[i]),
         .ldhit        (ldhit[i]),
         .stall        (stall[i]),
         .int_activate (int_activate[i]),
         .halt_thread  (halt_thread[i]),
         .start_thread (start_thread[i]),
         .nuke_thread  (nuke_thread[i]),
         .thaw_thread  (thaw_thread[i]),
         .rst_thread   (rst_thread[i]),
         .switch_out   (switch_out[i]),
         .sw_cond      (sw_cond),
         .dbg_wr_en    (dbg_wr_en[i]),
         .dbg_wr_data  (dbg_wr_data),
         .thr_state    (thread_states[i]),
         .thr_nstate   ()                    // next state not needed here
      );
   end

   thread_picker #(
      .NUM_THREADS (NUM_THREADS),
      .QUANTUM     (QUANTUM)
   ) picker0 (
      .clk           (clk),
      .reset         (reset),
      .thread_states (thread_states),
      .schedule      (schedule),
      .switch_out    (switch_out),
      .run_valid     (run_valid),
      .run_id        (run_id)
   );

   thread_dbg_wb #(
      .NUM_THREADS (NUM_THREADS)
   ) dbg0 (
      .clk           (clk),
      .reset         (reset),
      .wb_cyc        (wb_cyc),
      .wb_stb        (wb_stb),
      .wb_we         (wb_we),
      .wb_adr        (wb_adr),
      .wb_dat_w      (wb_dat_w),
      .thread_states (thread_states),
      .run_valid     (run_valid),
      .run_id        (run_id),
      .wb_dat_r      (wb_dat_r),
      .wb_ack        (wb_ack),
      .dbg_wr_en     (dbg_wr_en),
      .dbg_wr_data   (dbg_wr_data)
   );

endmodule

// File: source/thread_dbg_wb.sv
/* thread debug port
   wishbone classic slave to read thread states and overwrite parked threads */
`timescale 1ns/1ns

module thread_dbg_wb
   import thr_pkg::*;
   import wb_pkg::*;
#(
   parameter  int NUM_THREADS = 4,
   localparam int IDX_W       = $clog2(NUM_THREADS)
)
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    wb_cyc,
   input  logic                                    wb_stb,
   input  logic                                    wb_we,
   input  logic [WB_ADDR_W-1:0]                    wb_adr,
   input  logic [WB_DATA_W-1:0]                    wb_dat_w,
   input  logic [NUM_THREADS-1:0][THR_STATE_W-1:0] thread_states,
   input  logic                                    run_valid,
   input  logic [IDX_W-1:0]                        run_id,
   output logic [WB_DATA_W-1:0]                    wb_dat_r,
   output logic                                    wb_ack,
   output logic [NUM_THREADS-1:0]                  dbg_wr_en,     // one-hot
   output thr_state_e                              dbg_wr_data
);

   logic                   req;         // new request this cycle
   logic                   is_thread;
   logic [IDX_W-1:0]       addr_idx;
   logic [THR_STATE_W-1:0] wr_code;
   logic                   wr_ok;
   logic [WB_DATA_W-1:0]   rd_data;

   assign req       = wb_cyc && wb_stb && !wb_ack;   // ack cycle ends the request
   assign is_thread = (wb_adr < WB_ADDR_W'(NUM_THREADS));
   assign addr_idx  = wb_adr[IDX_W-1:0];
   assign wr_code   = wb_dat_w[THR_STATE_W-1:0];

   // rejected writes still get their ack
   assign wr_ok = req && wb_we && is_thread
                  && state_is_legal(wr_code)
                  && !state_is_running(wr_code)                 // host never starts a thread
                  && !state_is_running(thread_states[addr_idx]);

   assign dbg_wr_data = thr_state_e'(wr_code);

   always_comb
   begin
      for (int i = 0; i < NUM_THREADS; i++)
         dbg_wr_en[i] = wr_ok && (addr_idx == IDX_W'(i));
   end

   // read mux, unmapped addresses give zero
   always_comb
   begin
      rd_data = '0;
      if (is_thread)
         rd_data[THR_STATE_W-1:0] = thread_states[addr_idx];
      else if (wb_adr == DBG_STATUS_ADDR)
      begin
         rd_data[DBG_RUN_VALID_BIT]  = run_valid;
         rd_data[DBG_RUN_ID_W-1:0]   = DBG_RUN_ID_W'(run_id);
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         wb_ack <= 1'b0;
      else
         wb_ack <= req;   // single cycle pulse
   end

   always_ff @(posedge clk)
   begin
      if (req)
         wb_dat_r <= rd_data;   // valid with ack
   end

   // accepted write is visible in the addressed thread from the ack edge on
   a_wr_lands: assert property (
      @(posedge clk) disable iff (reset)
         wr_ok |=> (thread_states[$past(addr_idx)] == $past(wr_code))
   ) else $error("debug write to thread %0d did not take effect", $past(addr_idx));

endmodule

// File: source/thread_picker.sv
/* thread picker
   round-robin schedule of ready threads, time-slice switch-out, run status */
`timescale 1ns/1ns

module thread_picker
   import thr_pkg::*;
#(
   parameter  int NUM_THREADS = 4,
   parameter  int QUANTUM     = 8,
   localparam int IDX_W       = $clog2(NUM_THREADS)
)
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic [NUM_THREADS-1:0][THR_STATE_W-1:0] thread_states,
   output logic [NUM_THREADS-1:0]                  schedule,     // one-hot
   output logic [NUM_THREADS-1:0]                  switch_out,   // one-hot
   output logic                                    run_valid,
   output logic [IDX_W-1:0]                        run_id
);

   localparam int CNT_W = $clog2(QUANTUM + 1);

   logic [NUM_THREADS-1:0] ready;
   logic [NUM_THREADS-1:0] running;
   logic                   any_running;
   logic [IDX_W-1:0]       last_idx;    // last scheduled thread
   logic [IDX_W-1:0]       sched_idx;
   logic [IDX_W-1:0]       run_idx;
   logic [CNT_W-1:0]       slice_cnt;   // cycles in run, saturates
   logic                   slice_done;

   always_comb
   begin
      for (int i = 0; i < NUM_THREADS; i++)
      begin
         ready[i]   = state_is_ready(thread_states[i]);
         running[i] = state_is_running(thread_states[i]);
      end
   end

   assign any_running = |running;

   // search starts just after the last pick, wraps around
   always_comb
   begin
      int cand;
      logic found;
      schedule  = '0;
      sched_idx = last_idx;
      found     = 1'b0;
      for (int k = 1; k <= NUM_THREADS; k++)
      begin
         cand = (int'(last_idx) + k) % NUM_THREADS;
         if (!found && !any_running && ready[cand])
         begin
            schedule[cand] = 1'b1;
            sched_idx      = IDX_W'(cand);
            found          = 1'b1;
         end
      end
   end

   always_comb
   begin
      run_idx = '0;
      for (int i = 0; i < NUM_THREADS; i++)
         if (running[i])
            run_idx = IDX_W'(i);
   end

   assign slice_done = (slice_cnt == CNT_W'(QUANTUM));
   assign switch_out = (slice_done && |ready) ? running : '0;   // only if someone waits

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         last_idx  <= IDX_W'(NUM_THREADS - 1);   // thread 0 goes first
         slice_cnt <= '0;
         run_valid <= 1'b0;
         run_id    <= '0;
      end
      else
      begin
         if (|schedule)
         begin
            last_idx  <= sched_idx;
            slice_cnt <= CNT_W'(1);               // first run cycle counts as one
         end
         else if (any_running && !slice_done)
            slice_cnt <= slice_cnt + 1'b1;
         run_valid <= any_running;
         run_id    <= run_idx;
      end
   end

   // one fetch slot, even with host writes going on
   a_one_running: assert property (
      @(posedge clk) disable iff (reset) $onehot0(running)
   ) else $error("more than one thread running: %b", running);

   // a thread only enters a run state when picked in the cycle before
   a_run_needs_sched: assert property (
      @(posedge clk) disable iff (reset)
         (running & ~$past(running) & ~$past(schedule)) == '0
   ) else $error("thread entered run without schedule: %b", running);

endmodule

// File: source/thread_fsm.sv
/* per-thread state machine
   moves one hardware thread between its seven states, debug write wins */
`timescale 1ns/1ns

module thread_fsm
   import thr_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       completion,     // awaited op finished
   input  logic       schedule,       // picked by the thread picker
   input  logic       spec_ld,        // speculative switch in
   input  logic       ldhit,          // speculation confirmed
   input  logic       stall,          // ldmiss, imiss or trap
   input  logic       int_activate,
   input  logic       halt_thread,
   input  logic       start_thread,
   input  logic       nuke_thread,
   input  logic       thaw_thread,
   input  logic       rst_thread,
   input  logic       switch_out,     // time slice expired
   input  logic       sw_cond,        // wait for completion
   input  logic       dbg_wr_en,
   input  thr_state_e dbg_wr_data,
   output thr_state_e thr_state,
   output thr_state_e thr_nstate
);

   thr_state_e next_state;

   assign thr_nstate = next_state;

   // transition table, priority top to bottom within each state
   always_comb
   begin
      next_state = thr_state;   // hold by default
      case (thr_state)
         THR_IDLE:
         begin
            if (rst_thread || thaw_thread)
               next_state = THR_WAIT;
            else if (start_thread)
               next_state = THR_RDY;   // other events ignored while idle
         end
         THR_HALT:
         begin
            if (nuke_thread)
               next_state = THR_IDLE;
            else if (rst_thread || thaw_thread)
               next_state = THR_WAIT;
            else if (int_activate || start_thread)
               next_state = THR_RDY;
         end
         THR_RDY:
         begin
            if (stall)
               next_state = THR_WAIT;   // trap while parked
            else if (schedule)
               next_state = THR_RUN;
         end
         THR_RUN:
         begin
            if (stall || sw_cond)
               next_state = THR_WAIT;
            else if (switch_out)
               next_state = THR_RDY;    // slice used up, back in line
         end
         THR_WAIT:
         begin
            if (nuke_thread)
               next_state = THR_IDLE;
            else if (halt_thread)
               next_state = THR_HALT;
            else if (stall)
               next_state = THR_WAIT;   // still blocked
            else if (spec_ld)
               next_state = THR_SPEC_RDY;
            else if (completion)
               next_state = THR_RDY;
         end
         THR_SPEC_RDY:
         begin
            if (stall)
               next_state = THR_WAIT;
            else if (schedule && !ldhit)
               next_state = THR_SPEC_RUN;
            else if (schedule && ldhit)
               next_state = THR_RUN;    // hit arrived as it was picked
            else if (ldhit)
               next_state = THR_RDY;
         end
         THR_SPEC_RUN:
         begin
            if (stall || sw_cond)
               next_state = THR_WAIT;
            else if (ldhit && switch_out)
               next_state = THR_RDY;
            else if (ldhit)
               next_state = THR_RUN;    // speculation resolved, keep going
            else if (switch_out)
               next_state = THR_SPEC_RDY;
         end
         default:
         begin
            next_state = thr_state;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         thr_state <= THR_IDLE;
      else if (dbg_wr_en)
         thr_state <= dbg_wr_data;   // host overwrite
      else
         thr_state <= next_state;
   end

   // debug port filters codes, so only the seven encodings should ever appear
   a_state_legal: assert property (
      @(posedge clk) disable iff (reset) state_is_legal(thr_state)
   ) else $error("thread state %b is not a legal code", thr_state);

endmodule

// File: source/wb_pkg.sv
/* wishbone debug bus package
   bus widths and the register map of the thread debug port */
package wb_pkg;

   localparam int WB_ADDR_W = 4;   // 16 registers
   localparam int WB_DATA_W = 8;

   // thread state registers live at 0 .. NUM_THREADS-1
   localparam logic [WB_ADDR_W-1:0] DBG_STATUS_ADDR = 4'd15;   // read only

   // status register layout
   localparam int DBG_RUN_VALID_BIT = 7;
   localparam int DBG_RUN_ID_W      = 3;   // run_id in bits 2:0

endpackage

// File: source/thr_pkg.sv
/* thread state package
   5-bit thread state encoding and the helpers that classify a state */
package thr_pkg;

   localparam int THR_STATE_W = 5;   // state register width

   // encoding kept from the original thread control register
   typedef enum logic [THR_STATE_W-1:0] {
      THR_IDLE     = 5'b00000,
      THR_HALT     = 5'b00010,
      THR_RDY      = 5'b11001,
      THR_RUN      = 5'b00101,
      THR_WAIT     = 5'b00001,
      THR_SPEC_RDY = 5'b10011,
      THR_SPEC_RUN = 5'b00111
   } thr_state_e;

   // eligible for scheduling
   function automatic logic state_is_ready(logic [THR_STATE_W-1:0] s);
      return (s == THR_RDY) || (s == THR_SPEC_RDY);
   endfunction

   // owns the fetch slot
   function automatic logic state_is_running(logic [THR_STATE_W-1:0] s);
      return (s == THR_RUN) || (s == THR_SPEC_RUN);
   endfunction

   function automatic logic state_is_legal(logic [THR_STATE_W-1:0] s);
      case (s)
         THR_IDLE, THR_HALT, THR_RDY, THR_RUN,
         THR_WAIT, THR_SPEC_RDY, THR_SPEC_RUN: return 1'b1;
         default:                              return 1'b0;   // any other code
      endcase
   endfunction

endpackage
